//--- ps2_kbd.f
source/ps2_kbd_pkg.sv
source/ps2_rx.sv
source/scan_fifo.sv
source/kbd_bus_port.sv
source/ps2_kbd_top.sv
tests/tb_ps2_kbd_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PS/2 keyboard port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ps2_kbd_top \
    -f ps2_kbd.f \
    -o sim_ps2_kbd

./obj_dir/sim_ps2_kbd > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"

//--- source/kbd_bus_port.sv
`timescale 1ns/100ps

module kbd_bus_port (
    input  logic                               system_clk,
    input  logic                               rst_n,
    input  logic [ps2_kbd_pkg::SCAN_W-1:0]     head,         // FIFO head byte
    input  logic                               empty,
    input  logic [ps2_kbd_pkg::FIFO_LVL_W-1:0] level,
    input  logic                               overrun,      // FIFO drop strobe
    input  logic                               frame_error,  // Receiver bad frame strobe
    output logic                               pop,
    input  logic [ps2_kbd_pkg::ADDR_W-1:0]     address,
    input  logic                               read,         // Bus read strobe
    output logic [ps2_kbd_pkg::BUS_W-1:0]      read_data     // Registered response
);

    import ps2_kbd_pkg::*;

    logic               skip_q;                  // Next byte ends a break sequence
    logic [ASCII_W-1:0] char_q;                  // Held character
    logic               ready_q;                 // Character not yet read
    logic               ovr_q;                   // Sticky overrun
    logic               ferr_q;                  // Sticky frame error
    logic               data_rd;
    logic               status_rd;
    logic [BUS_W-1:0]   status_word;

    // Set-2 make codes to ASCII
    function automatic logic [ASCII_W-1:0] to_ascii(input logic [SCAN_W-1:0] sc);
        case (sc)
            8'h45:   to_ascii = 7'd48;           // 0
            8'h16:   to_ascii = 7'd49;           // 1
            8'h1E:   to_ascii = 7'd50;           // 2
            8'h26:   to_ascii = 7'd51;           // 3
            8'h25:   to_ascii = 7'd52;           // 4
            8'h2E:   to_ascii = 7'd53;           // 5
            8'h36:   to_ascii = 7'd54;           // 6
            8'h3D:   to_ascii = 7'd55;           // 7
            8'h3E:   to_ascii = 7'd56;           // 8
            8'h46:   to_ascii = 7'd57;           // 9
            8'h1C:   to_ascii = 7'd65;           // A
            8'h32:   to_ascii = 7'd66;           // B
            8'h21:   to_ascii = 7'd67;           // C
            8'h23:   to_ascii = 7'd68;           // D
            8'h24:   to_ascii = 7'd69;           // E
            8'h2B:   to_ascii = 7'd70;           // F
            8'h34:   to_ascii = 7'd71;           // G
            8'h33:   to_ascii = 7'd72;           // H
            8'h43:   to_ascii = 7'd73;           // I
            8'h3B:   to_ascii = 7'd74;           // J
            8'h42:   to_ascii = 7'd75;           // K
            8'h4B:   to_ascii = 7'd76;           // L
            8'h3A:   to_ascii = 7'd77;           // M
            8'h31:   to_ascii = 7'd78;           // N
            8'h44:   to_ascii = 7'd79;           // O
            8'h4D:   to_ascii = 7'd80;           // P
            8'h15:   to_ascii = 7'd81;           // Q
            8'h2D:   to_ascii = 7'd82;           // R
            8'h1B:   to_ascii = 7'd83;           // S
            8'h2C:   to_ascii = 7'd84;           // T
            8'h3C:   to_ascii = 7'd85;           // U
            8'h2A:   to_ascii = 7'd86;           // V
            8'h1D:   to_ascii = 7'd87;           // W
            8'h22:   to_ascii = 7'd88;           // X
            8'h35:   to_ascii = 7'd89;           // Y
            8'h1A:   to_ascii = 7'd90;           // Z
            default: to_ascii = UNKNOWN_ASCII;   // E0 and unmapped keys
        endcase
    endfunction

    assign pop       = ~empty & ~ready_q;        // Stall while a character waits
    assign data_rd   = read & (address == KBD_DATA_ADDR);
    assign status_rd = read & (address == KBD_STATUS_ADDR);

    always_comb begin
        status_word                                    = '0;
        status_word[STAT_READY_BIT]                    = ready_q;
        status_word[STAT_OVERRUN_BIT]                  = ovr_q;
        status_word[STAT_FRAME_ERR_BIT]                = ferr_q;
        status_word[STAT_LEVEL_LSB +: FIFO_LVL_W]      = level;
    end

    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            skip_q  <= 1'b0;
            char_q  <= '0;
            ready_q <= 1'b0;
            ovr_q   <= 1'b0;
            ferr_q  <= 1'b0;
        end else begin
            if (data_rd) begin
                ready_q <= 1'b0;                 // Host took the character
            end
            if (pop) begin
                if (skip_q) begin
                    skip_q <= 1'b0;              // Released key code discarded
                end else if (head == BREAK_CODE) begin
                    skip_q <= 1'b1;
                end else begin
                    char_q  <= to_ascii(head);
                    ready_q <= 1'b1;             // Wins over a same-cycle data read
                end
            end
            ovr_q  <= overrun | (ovr_q & ~status_rd);       // New event survives the clear
            ferr_q <= frame_error | (ferr_q & ~status_rd);
        end
    end

    // One-cycle response after the strobe
    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (data_rd) begin
            read_data <= BUS_W'(char_q);
        end else if (status_rd) begin
            read_data <= status_word;
        end else begin
            read_data <= '0;
        end
    end

    // FIFO empty comes from scan_fifo
    a_pop_legal: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        pop |-> (!empty && !ready_q)
    ) else $error("kbd_bus_port pop while empty or holding a character");

    a_idle_bus_zero: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        !read |=> (read_data == '0)
    ) else $error("kbd_bus_port read_data not zero after idle cycle");

endmodule

//--- source/ps2_kbd_pkg.sv
package ps2_kbd_pkg;

    // Host bus
    localparam int ADDR_W = 14;                             // Bus address width
    localparam int BUS_W  = 64;                             // Read word width

    localparam logic [ADDR_W-1:0] KBD_DATA_ADDR   = 14'h2500;   // Character register
    localparam logic [ADDR_W-1:0] KBD_STATUS_ADDR = 14'h2501;   // Status word

    // PS/2 frame layout
    localparam int SCAN_W     = 8;                          // One scan byte
    localparam int FRAME_BITS = 11;                         // Start bit, byte, parity and stop
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);         // Holds 0 to 10

    // Receiver watchdog
    localparam int RX_IDLE_TIMEOUT = 2000;                  // Cycles without a fall mid-frame
    localparam int RX_TMR_W        = $clog2(RX_IDLE_TIMEOUT + 1);

    // Type-ahead buffer
    localparam int FIFO_DEPTH = 8;                          // Scan bytes held
    localparam int FIFO_LVL_W = 4;                          // Level 0 to 8
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);         // Circular index

    // Scan code handling
    localparam logic [SCAN_W-1:0] BREAK_CODE = 8'hF0;       // Key release prefix
    localparam int ASCII_W = 7;                             // 7-bit ASCII character
    localparam logic [ASCII_W-1:0] UNKNOWN_ASCII = 7'd63;   // Shown as '?'

    // Status word bit positions
    localparam int STAT_READY_BIT     = 0;                  // Character waiting
    localparam int STAT_OVERRUN_BIT   = 1;                  // Sticky FIFO drop
    localparam int STAT_FRAME_ERR_BIT = 2;                  // Sticky bad frame
    localparam int STAT_LEVEL_LSB     = 4;                  // Level in bits 7 to 4

endpackage

//--- source/ps2_kbd_top.sv
`timescale 1ns/100ps

module ps2_kbd_top (
    input  logic                           system_clk,
    input  logic                           rst_n,
    input  logic                           ps2_clk,     // Keyboard clock, idle high
    input  logic                           ps2_data,    // Keyboard data, idle high
    input  logic [ps2_kbd_pkg::ADDR_W-1:0] address,
    input  logic                           read,
    output logic [ps2_kbd_pkg::BUS_W-1:0]  read_data
);

    import ps2_kbd_pkg::*;

    logic [SCAN_W-1:0]     code;            // Receiver to FIFO
    logic                  code_valid;
    logic                  frame_error;     // Receiver to bus port
    logic [SCAN_W-1:0]     head;            // FIFO to bus port
    logic                  empty;
    logic [FIFO_LVL_W-1:0] level;
    logic                  overrun;
    logic                  pop;             // Bus port to FIFO

    ps2_rx i_ps2_rx (
        .system_clk  (system_clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .code        (code),
        .code_valid  (code_valid),
        .frame_error (frame_error)
    );

    scan_fifo i_scan_fifo (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .push       (code_valid),
        .push_data  (code),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .level      (level),
        .overrun    (overrun)
    );

    kbd_bus_port i_kbd_bus_port (
        .system_clk  (system_clk),
        .rst_n       (rst_n),
        .head        (head),
        .empty       (empty),
        .level       (level),
        .overrun     (overrun),
        .frame_error (frame_error),
        .pop         (pop),
        .address     (address),
        .read        (read),
        .read_data   (read_data)
    );

endmodule

//--- source/ps2_rx.sv
`timescale 1ns/100ps

module ps2_rx (
    input  logic                           system_clk,
    input  logic                           rst_n,
    input  logic                           ps2_clk,      // Keyboard clock, async
    input  logic                           ps2_data,     // Keyboard data, async
    output logic [ps2_kbd_pkg::SCAN_W-1:0] code,         // Last good scan byte
    output logic                           code_valid,   // Good frame strobe
    output logic                           frame_error   // Bad frame strobe
);

    import ps2_kbd_pkg::*;

    logic [1:0]            clk_sync;                     // ps2_clk double flop
    logic [1:0]            data_sync;                    // ps2_data double flop
    logic                  clk_prev;                     // Previous synced clock
    logic                  clk_fall;                     // Sample strobe
    logic [BIT_CNT_W-1:0]  bit_cnt;                      // Position in frame
    logic [RX_TMR_W-1:0]   idle_tmr;                     // Cycles since last fall
    logic [FRAME_BITS-2:0] frame_q;                      // Start, byte and parity
    logic                  last_bit;                     // Stop bit being sampled
    logic                  start_ok;
    logic                  parity_ok;
    logic                  stop_ok;
    logic                  frame_ok;

    // Both lines idle high so the synchronizers reset to one
    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];           // Keyboard drives data before fall
    assign last_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    // Frame checks valid while the stop bit sits on the synced data line
    assign start_ok  = ~frame_q[0];                      // Start must be low
    assign parity_ok = ^frame_q[SCAN_W+1:1];             // Odd over byte and parity
    assign stop_ok   = data_sync[1];                     // Stop must be high
    assign frame_ok  = start_ok & parity_ok & stop_ok;

    // LSB first so the newest bit enters at the top
    always_ff @(posedge system_clk) begin
        if (clk_fall) begin
            frame_q <= {data_sync[1], frame_q[FRAME_BITS-2:1]};
            if (last_bit) begin
                code <= frame_q[SCAN_W:1];               // Data byte between start and parity
            end
        end
    end

    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            bit_cnt     <= '0;
            idle_tmr    <= '0;
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            code_valid  <= 1'b0;                         // Strobes last one cycle
            frame_error <= 1'b0;
            if (clk_fall) begin
                idle_tmr <= '0;
                if (last_bit) begin
                    bit_cnt     <= '0;
                    code_valid  <= frame_ok;
                    frame_error <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt != '0) begin            // Watchdog only mid-frame
                if (idle_tmr == RX_TMR_W'(RX_IDLE_TIMEOUT - 1)) begin
                    bit_cnt  <= '0;                      // Drop the partial frame quietly
                    idle_tmr <= '0;
                end else begin
                    idle_tmr <= idle_tmr + 1'b1;
                end
            end
        end
    end

    a_bit_cnt_range: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        bit_cnt <= BIT_CNT_W'(FRAME_BITS - 1)
    ) else $error("ps2_rx bit count out of range: %0d", bit_cnt);

    // One verdict per frame
    a_one_verdict: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        !(code_valid && frame_error)
    ) else $error("ps2_rx code_valid and frame_error together");

endmodule

//--- source/scan_fifo.sv
`timescale 1ns/100ps

module scan_fifo (
    input  logic                               system_clk,
    input  logic                               rst_n,
    input  logic                               push,        // Write strobe
    input  logic [ps2_kbd_pkg::SCAN_W-1:0]     push_data,
    input  logic                               pop,         // Drop the head entry
    output logic [ps2_kbd_pkg::SCAN_W-1:0]     head,        // Oldest entry, fall-through
    output logic                               empty,
    output logic [ps2_kbd_pkg::FIFO_LVL_W-1:0] level,       // Entries held
    output logic                               overrun      // Byte dropped last cycle
);

    import ps2_kbd_pkg::*;

    logic [SCAN_W-1:0]     mem [FIFO_DEPTH];                // Scan byte storage
    logic [FIFO_PTR_W-1:0] wr_ptr;                          // Next free slot
    logic [FIFO_PTR_W-1:0] rd_ptr;                          // Oldest entry
    logic [FIFO_LVL_W-1:0] count;                           // Occupancy
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    // Wrap at the last slot so any depth works
    function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
        if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            ptr_inc = '0;
        end else begin
            ptr_inc = ptr + 1'b1;
        end
    endfunction

    assign full    = (count == FIFO_LVL_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_pop  = pop & ~empty;                          // Ignore pop on empty
    assign do_push = push & (~full | do_pop);               // Full is fine if a slot frees now

    assign head  = mem[rd_ptr];
    assign level = count;

    always_ff @(posedge system_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                    // Both or neither
            endcase
            overrun <= push & full & ~do_pop;               // Lost byte
        end
    end

    // Consumer must respect empty
    a_no_pop_empty: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        pop |-> !empty
    ) else $error("scan_fifo pop while empty");

    a_level_bound: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        level <= FIFO_LVL_W'(FIFO_DEPTH)
    ) else $error("scan_fifo level above depth: %0d", level);

endmodule

//--- tests/tb_ps2_kbd_top.sv
`timescale 1ns/100ps

module tb_ps2_kbd_top;

    import ps2_kbd_pkg::*;

    logic              system_clk = 1'b0;
    logic              rst_n;
    logic              ps2_clk;
    logic              ps2_data;
    logic [ADDR_W-1:0] address;
    logic              read;
    logic [BUS_W-1:0]  read_data;

    logic              read_seen = 1'b0;      // Strobe sampled at the last edge
    logic [BUS_W-1:0]  exp_value;             // Expected response
    logic [BUS_W-1:0]  exp_mask;              // Checked bits
    string             exp_name;              // Signal label for error lines
    int                cmp_checks = 0;
    int                cmp_errors = 0;
    int                run_errors = 0;        // Timeouts and other plain failures
    int                tests_run = 0;
    int                tests_failed = 0;
    int                test_start_errors = 0;
    logic              timed_out = 1'b0;
    logic [31:0]       lcg_state = 32'h8b2b_61b9;
    logic [BUS_W-1:0]  ready_mask;
    logic [BUS_W-1:0]  all_mask;

    // Set-2 make codes where the index gives the character offset
    logic [SCAN_W-1:0] digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25,
                                            8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
    logic [SCAN_W-1:0] letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
                                             8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B,
                                             8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
                                             8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22,
                                             8'h35, 8'h1A};
    logic [SCAN_W-1:0] key_order [36];        // Shuffled mapped codes
    logic [SCAN_W-1:0] typed [10];            // Type-ahead burst

    ps2_kbd_top i_ps2_kbd_top (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .address    (address),
        .read       (read),
        .read_data  (read_data)
    );

    always #4 system_clk = ~system_clk;       // 8 ns period

    always @(posedge system_clk) begin
        read_seen <= read;                    // Response due after this edge
    end

    // Mid-cycle compare while read_data is stable between edges
    always @(negedge system_clk) begin
        if (rst_n === 1'b1) begin
            if (read_seen) begin
                if (exp_mask != '0) begin     // Status polls carry no expectation
                    cmp_checks = cmp_checks + 1;
                    assert ((read_data & exp_mask) == (exp_value & exp_mask)) else begin
                        $display("** Error at %0d ns: %s expected %h got %h", $time,
                                 exp_name, exp_value & exp_mask, read_data & exp_mask);
                        cmp_errors = cmp_errors + 1;
                    end
                end
            end else begin
                assert (read_data == '0) else begin
                    $display("** Error at %0d ns: read_data (idle) expected %h got %h",
                             $time, {BUS_W{1'b0}}, read_data);
                    cmp_errors = cmp_errors + 1;
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pick(input int n);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[31:16]) % n;    // Upper bits are the better ones
    endfunction

    // Expected character is '?' unless the code is a digit or letter key
    function automatic logic [ASCII_W-1:0] ref_ascii(input logic [SCAN_W-1:0] sc);
        logic [ASCII_W-1:0] a;
        a = 7'd63;
        for (int i = 0; i < 10; i++) begin
            if (digit_codes[i] == sc) begin
                a = 7'd48 + 7'(i);
            end
        end
        for (int i = 0; i < 26; i++) begin
            if (letter_codes[i] == sc) begin
                a = 7'd65 + 7'(i);
            end
        end
        return a;
    endfunction

    function automatic logic [BUS_W-1:0] status_bits(input logic rdy, input logic ovr,
                                                     input logic ferr, input logic [3:0] lvl);
        logic [BUS_W-1:0] w;
        w                                 = '0;
        w[STAT_READY_BIT]                 = rdy;
        w[STAT_OVERRUN_BIT]               = ovr;
        w[STAT_FRAME_ERR_BIT]             = ferr;
        w[STAT_LEVEL_LSB +: FIFO_LVL_W]   = lvl;
        return w;
    endfunction

    task automatic next_edge();
        @(posedge system_clk);
        #1;                                   // Drive just after the edge
    endtask

    // Keyboard side with 20 system cycles per PS/2 half period
    task automatic send_frame(input logic [SCAN_W-1:0] sc, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, (~^sc) ^ bad_parity, sc, 1'b0};   // Stop, odd parity, byte, start
        next_edge();
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];               // Data changes while clock is high
            repeat (20) next_edge();
            ps2_clk = 1'b0;                   // Receiver samples on this fall
            repeat (20) next_edge();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (40) next_edge();              // Gap between frames
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic [BUS_W-1:0] value,
                            input logic [BUS_W-1:0] mask, input string name,
                            output logic [BUS_W-1:0] data);
        next_edge();
        exp_value = value;                    // Previous response already compared
        exp_mask  = mask;
        exp_name  = name;
        address   = addr;
        read      = 1'b1;
        next_edge();
        read      = 1'b0;
        data      = read_data;                // Valid for this one cycle
    endtask

    task automatic check_status(input logic [BUS_W-1:0] value, input logic [BUS_W-1:0] mask);
        logic [BUS_W-1:0] word;
        bus_read(KBD_STATUS_ADDR, value, mask, "read_data (status)", word);
    endtask

    task automatic check_data(input logic [ASCII_W-1:0] ascii);
        logic [BUS_W-1:0] word;
        bus_read(KBD_DATA_ADDR, BUS_W'(ascii), '1, "read_data (character)", word);
    endtask

    task automatic wait_ready(input string what);
        logic [BUS_W-1:0] word;
        int               polls;
        word  = '0;
        polls = 0;
        while (!word[STAT_READY_BIT] && polls < 100) begin
            bus_read(KBD_STATUS_ADDR, '0, '0, "read_data (poll)", word);
            polls++;
        end
        if (!word[STAT_READY_BIT]) begin
            $display("Timeout: no character became ready (%s) after %0d status polls",
                     what, polls);
            run_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic begin_test();
        test_start_errors = cmp_errors + run_errors;
    endtask

    task automatic end_test(input string name);
        int errs;
        next_edge();                          // Last response compared by now
        errs = cmp_errors + run_errors - test_start_errors;
        tests_run++;
        if (errs == 0) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errs);
        end
    endtask

    // Fisher-Yates over the 36 mapped codes
    task automatic shuffle_keys();
        int                j;
        logic [SCAN_W-1:0] t;
        for (int i = 0; i < 10; i++) begin
            key_order[i] = digit_codes[i];
        end
        for (int i = 0; i < 26; i++) begin
            key_order[10 + i] = letter_codes[i];
        end
        for (int i = 35; i > 0; i--) begin
            j            = pick(i + 1);
            t            = key_order[i];
            key_order[i] = key_order[j];
            key_order[j] = t;
        end
    endtask

    task automatic test_make_codes();
        begin_test();
        for (int i = 0; i < 36; i++) begin
            send_frame(key_order[i], 1'b0, 1'b0);
            wait_ready("make code");
            check_status(status_bits(1'b1, 1'b0, 1'b0, 4'd0), all_mask);   // Byte popped
            check_data(ref_ascii(key_order[i]));
            check_status('0, ready_mask | status_bits(1'b0, 1'b0, 1'b0, 4'hF));  // Cleared
        end
        end_test("make codes");
    endtask

    task automatic test_break_prefix();
        logic [SCAN_W-1:0] released [2];
        logic [SCAN_W-1:0] next_key;
        begin_test();
        released[0] = key_order[pick(36)];
        released[1] = 8'hE0;
        for (int i = 0; i < 2; i++) begin
            send_frame(BREAK_CODE, 1'b0, 1'b0);
            send_frame(released[i], 1'b0, 1'b0);
            check_status('0, ready_mask | status_bits(1'b0, 1'b0, 1'b0, 4'hF));  // Both consumed
            next_key = key_order[pick(36)];
            send_frame(next_key, 1'b0, 1'b0);
            wait_ready("after break");
            check_data(ref_ascii(next_key));
        end
        end_test("break prefix");
    endtask

    task automatic test_unmapped();
        logic [SCAN_W-1:0] odd_codes [3];
        begin_test();
        odd_codes[0] = 8'h0D;                 // Tab
        odd_codes[1] = 8'hE0;                 // Extended prefix
        odd_codes[2] = 8'h76;                 // Escape
        for (int i = 0; i < 3; i++) begin
            send_frame(odd_codes[i], 1'b0, 1'b0);
            wait_ready("unmapped code");
            check_data(ref_ascii(odd_codes[i]));
        end
        end_test("unmapped codes");
    endtask

    task automatic test_frame_errors();
        begin_test();
        for (int i = 0; i < 2; i++) begin
            send_frame(key_order[pick(36)], i == 0, i == 1);   // Parity first, then stop
            check_status(status_bits(1'b0, 1'b0, 1'b1, 4'd0), all_mask);
            check_status('0, all_mask);       // Sticky bit cleared by the read
        end
        end_test("frame errors");
    endtask

    task automatic test_type_ahead();
        begin_test();
        for (int i = 0; i < 10; i++) begin
            typed[i] = key_order[pick(36)];
            send_frame(typed[i], 1'b0, 1'b0);
        end
        check_status(status_bits(1'b1, 1'b1, 1'b0, 4'd8), all_mask);   // Tenth was dropped
        for (int i = 0; i < 9; i++) begin
            wait_ready("type-ahead");
            check_data(ref_ascii(typed[i]));
        end
        check_status('0, all_mask);
        end_test("type-ahead and overrun");
    endtask

    task automatic test_other_addresses();
        logic [ADDR_W-1:0] addrs [5];
        logic [BUS_W-1:0]  word;
        logic [SCAN_W-1:0] key;
        begin_test();
        key = key_order[pick(36)];
        send_frame(key, 1'b0, 1'b0);
        wait_ready("other addresses");        // A character waits during the reads
        addrs[0] = 14'h0000;
        addrs[1] = 14'h24FF;
        addrs[2] = 14'h2502;
        addrs[3] = 14'h3FFF;
        addrs[4] = 14'h1000 + ADDR_W'(pick(256));
        for (int i = 0; i < 5; i++) begin
            bus_read(addrs[i], '0, '1, "read_data (unmapped address)", word);
        end
        check_data(ref_ascii(key));
        end_test("other addresses");
    endtask

    initial begin
        rst_n      = 1'b0;
        ps2_clk    = 1'b1;                    // PS/2 lines idle high
        ps2_data   = 1'b1;
        address    = '0;
        read       = 1'b0;
        ready_mask = status_bits(1'b1, 1'b0, 1'b0, 4'd0);
        all_mask   = status_bits(1'b1, 1'b1, 1'b1, 4'hF);
        repeat (10) @(posedge system_clk);
        #1 rst_n = 1'b1;
        shuffle_keys();
        if (!timed_out) test_make_codes();
        if (!timed_out) test_break_prefix();
        if (!timed_out) test_unmapped();
        if (!timed_out) test_frame_errors();
        if (!timed_out) test_type_ahead();
        if (!timed_out) test_other_addresses();
        if (timed_out) begin
            $display("Run stopped early after a timeout");
        end
        $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, cmp_checks, cmp_errors + run_errors);
        if (cmp_errors + run_errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
